// File: source/rdrv_pkg.sv
/* Shared widths, limits and types of the read-traffic driver
   Expected data is a fixed rule on the word address, not a memory image */

`default_nettype none

package rdrv_pkg;

    // Bus and tracker sizing
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int ID_W       = 8;
    localparam int OSTD_NUM   = 8;
    localparam int SLOT_IDX_W = 3;

    // Both the slot age and the AR stall limit
    localparam int TIMEOUT = 100;
    localparam int TIMER_W = $clog2(TIMEOUT + 1);

    // Random gap before arvalid spans 0 to 31 cycles
    localparam int GAP_W = 5;

    localparam int          LFSR_W    = 32;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam logic [31:0] LFSR_KEY  = 32'h28346450;
    localparam logic [31:0] DATA_KEY  = 32'h5a5a0f0f;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
    } ar_req_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
    } r_beat_t;

    // Sticky, cleared by reset only
    typedef struct packed {
        logic id_err;
        logic data_err;
        logic slot_timeout;
        logic ar_timeout;
    } err_flags_t;

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_WAIT,
        GEN_VALID
    } gen_state_t;

    // Galois step, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [LFSR_W-1:0] lfsr_next(input logic [LFSR_W-1:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] word_addr;
        word_addr = addr >> 2;
        return DATA_W'(word_addr) ^ DATA_KEY;
    endfunction

endpackage

`default_nettype wire

// File: source/read_request_gen.sv
/* Issues word-aligned read addresses in batches of 1 to OSTD_NUM beats
   Holds back while the slot at the request pointer is still busy */

`timescale 1ns/1ps
`default_nettype none

module read_request_gen (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          en,
    input  logic [rdrv_pkg::OSTD_NUM-1:0] busy,
    input  logic                          arready,
    output logic                          arvalid,
    output rdrv_pkg::ar_req_t             ar,
    output logic [rdrv_pkg::OSTD_NUM-1:0] load,
    output logic                          ar_timeout
);
    import rdrv_pkg::*;

    gen_state_t            state;
    logic [LFSR_W-1:0]     lfsr;
    logic [GAP_W-1:0]      gap_cnt;
    logic [SLOT_IDX_W-1:0] req_ptr;
    logic [SLOT_IDX_W:0]   batch_len;
    logic [SLOT_IDX_W:0]   beat_cnt;
    logic [SLOT_IDX_W:0]   next_len;
    logic [TIMER_W-1:0]    stall_cnt;
    logic                  handshake;

    assign handshake  = arvalid && arready;
    assign arvalid    = (state == GEN_VALID);
    assign load       = handshake ? (OSTD_NUM'(1) << req_ptr) : '0;
    assign ar_timeout = (stall_cnt == TIMER_W'(TIMEOUT));

    // Zero becomes a single beat, anything above the slot count is capped
    always_comb begin
        if (lfsr[SLOT_IDX_W:0] == '0) begin
            next_len = (SLOT_IDX_W + 1)'(1);
        end else if (lfsr[SLOT_IDX_W:0] > OSTD_NUM) begin
            next_len = (SLOT_IDX_W + 1)'(OSTD_NUM);
        end else begin
            next_len = lfsr[SLOT_IDX_W:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Valid FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= GEN_IDLE;
            lfsr    <= LFSR_KEY;
            gap_cnt <= '0;
        end else begin
            lfsr <= lfsr_next(lfsr);
            case (state)
                GEN_IDLE: begin
                    if (en) begin
                        gap_cnt <= lfsr[28:24];
                        state   <= GEN_WAIT;
                    end
                end
                GEN_WAIT: begin
                    if (!en) begin
                        state <= GEN_IDLE;
                    end else if (gap_cnt != '0) begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end else if (!busy[req_ptr]) begin
                        state <= GEN_VALID;
                    end
                end
                // Held until accepted, even if en drops meanwhile
                GEN_VALID: begin
                    if (arready) begin
                        gap_cnt <= lfsr[28:24];
                        state   <= en ? GEN_WAIT : GEN_IDLE;
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Address, ID and batch tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ar        <= '0;
            req_ptr   <= '0;
            beat_cnt  <= '0;
            batch_len <= (SLOT_IDX_W + 1)'(OSTD_NUM);
        end else if (handshake) begin
            req_ptr <= req_ptr + 1'b1;
            if (beat_cnt == batch_len - 1'b1) begin
                ar.id     <= ar.id + 1'b1;
                ar.addr   <= ADDR_W'({lfsr[19:2], 2'b00});
                batch_len <= next_len;
                beat_cnt  <= '0;
            end else begin
                ar.addr  <= ar.addr + ADDR_W'(4);
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Stall timer saturates at the limit
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            stall_cnt <= '0;
        end else if (!arvalid || arready) begin
            stall_cnt <= '0;
        end else if (!ar_timeout) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    // The slot at the request pointer stays free while arvalid is up
    free_slot_a: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid |-> !busy[req_ptr]);

endmodule

`default_nettype wire

// File: source/outstanding_slot.sv
/* Holds one outstanding read request and ages it while busy
   A release and a new load may arrive in the same cycle */

`timescale 1ns/1ps
`default_nettype none

module outstanding_slot (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              load,
    input  rdrv_pkg::ar_req_t req,
    input  logic              rel,
    output logic              busy,
    output rdrv_pkg::ar_req_t entry,
    output logic              timeout
);
    import rdrv_pkg::*;

    logic [TIMER_W-1:0] age;

    assign timeout = busy && (age == TIMER_W'(TIMEOUT));

    ////////////////////////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////////////////////////

    // Load wins over release so a freed slot can refill at once
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (rel) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            entry <= req;
        end
    end

    ////////////////////////////////////////////////////////////
    // Age timer
    ////////////////////////////////////////////////////////////

    // Restarts on every new request, stops at the limit
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            age <= '0;
        end else if (load || rel || !busy) begin
            age <= '0;
        end else if (age != TIMER_W'(TIMEOUT)) begin
            age <= age + 1'b1;
        end
    end

    // The generator must not overwrite a live request
    no_overwrite_a: assert property (@(posedge aclk) disable iff (!aresetn)
        load |-> (!busy || rel));

endmodule

`default_nettype wire

// File: source/completion_checker.sv
/* Retires read responses in request order and checks ID and data
   Error flags are sticky until reset, rready stalls in random runs */

`timescale 1ns/1ps
`default_nettype none

module completion_checker (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          en,
    input  logic                          rvalid,
    input  rdrv_pkg::r_beat_t             r,
    input  rdrv_pkg::ar_req_t             entries [rdrv_pkg::OSTD_NUM],
    input  logic [rdrv_pkg::OSTD_NUM-1:0] busy,
    input  logic [rdrv_pkg::OSTD_NUM-1:0] slot_timeouts,
    input  logic                          ar_timeout,
    output logic                          rready,
    output logic [rdrv_pkg::OSTD_NUM-1:0] rel,
    output rdrv_pkg::err_flags_t          errors,
    output logic                          error
);
    import rdrv_pkg::*;

    logic [LFSR_W-1:0]     lfsr;
    logic [LFSR_W-1:0]     ready_pat;
    logic [SLOT_IDX_W-1:0] cpl_ptr;
    ar_req_t               cur;
    logic                  handshake;

    assign handshake = rvalid && rready;
    assign cur       = entries[cpl_ptr];
    assign rel       = handshake ? (OSTD_NUM'(1) << cpl_ptr) : '0;
    assign error     = |errors;

    ////////////////////////////////////////////////////////////
    // rready pattern
    ////////////////////////////////////////////////////////////

    // Low bits of a fresh LFSR word give the length of the stall
    assign rready = ready_pat[0];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lfsr      <= {LFSR_KEY[15:0], LFSR_KEY[31:16]};
            ready_pat <= '0;
        end else if (en) begin
            lfsr <= lfsr_next(lfsr);
            if (ready_pat == '0 || handshake) begin
                ready_pat <= lfsr;
            end else if (!ready_pat[0]) begin
                ready_pat <= ready_pat >> 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // In-order completion and checks
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cpl_ptr <= '0;
            errors  <= '0;
        end else begin
            if (handshake) begin
                cpl_ptr <= cpl_ptr + 1'b1;
                if (r.id != cur.id) begin
                    errors.id_err <= 1'b1;
                end
                if (r.data != expected_word(cur.addr)) begin
                    errors.data_err <= 1'b1;
                end
            end
            if (|slot_timeouts) begin
                errors.slot_timeout <= 1'b1;
            end
            if (ar_timeout) begin
                errors.ar_timeout <= 1'b1;
            end
        end
    end

    // Responder may only answer requests that are still tracked
    r_on_busy_slot_a: assert property (@(posedge aclk) disable iff (!aresetn)
        handshake |-> busy[cpl_ptr]);

endmodule

`default_nettype wire

// File: source/read_traffic_driver.sv
/* Read-only traffic driver, up to OSTD_NUM requests in flight
   Responses must return in request order */

`timescale 1ns/1ps
`default_nettype none

module read_traffic_driver (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 en,
    output logic                 arvalid,
    input  logic                 arready,
    output rdrv_pkg::ar_req_t    ar,
    input  logic                 rvalid,
    output logic                 rready,
    input  rdrv_pkg::r_beat_t    r,
    output rdrv_pkg::err_flags_t errors,
    output logic                 error
);
    import rdrv_pkg::*;

    logic [OSTD_NUM-1:0] busy;
    logic [OSTD_NUM-1:0] load;
    logic [OSTD_NUM-1:0] rel;
    logic [OSTD_NUM-1:0] slot_timeouts;
    logic                ar_timeout;
    ar_req_t             entries [OSTD_NUM];

    read_request_gen i_read_request_gen (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .en         (en),
        .busy       (busy),
        .arready    (arready),
        .arvalid    (arvalid),
        .ar         (ar),
        .load       (load),
        .ar_timeout (ar_timeout)
    );

    ////////////////////////////////////////////////////////////
    // Outstanding request slots
    ////////////////////////////////////////////////////////////

    // Every slot sees the AR payload, only the loaded one keeps it
    for (genvar i = 0; i < OSTD_NUM; i++) begin : g_slot
        outstanding_slot i_outstanding_slot (
            .aclk    (aclk),
            .aresetn (aresetn),
            .load    (load[i]),
            .req     (ar),
            .rel     (rel[i]),
            .busy    (busy[i]),
            .entry   (entries[i]),
            .timeout (slot_timeouts[i])
        );
    end

    completion_checker i_completion_checker (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .en            (en),
        .rvalid        (rvalid),
        .r             (r),
        .entries       (entries),
        .busy          (busy),
        .slot_timeouts (slot_timeouts),
        .ar_timeout    (ar_timeout),
        .rready        (rready),
        .rel           (rel),
        .errors        (errors),
        .error         (error)
    );

endmodule

`default_nettype wire

// File: bench/read_traffic_monitor.sv
/* Watches the driver ports, counts handshakes and grades each test on its flags
   All counters clear while reset is asserted */

`timescale 1ns/1ps
`default_nettype none

module read_traffic_monitor (
    input logic                 aclk,
    input logic                 aresetn,
    input logic                 arvalid,
    input logic                 arready,
    input rdrv_pkg::ar_req_t    ar,
    input logic                 rvalid,
    input logic                 rready,
    input rdrv_pkg::err_flags_t errors,
    input logic                 error
);
    import rdrv_pkg::*;

    int      ar_count;
    int      r_count;
    int      peak_inflight;
    int      violations;
    int      extra_problems = 0;
    int      tests_run      = 0;
    int      tests_failed   = 0;
    logic    prev_wait;
    ar_req_t prev_ar;
    ar_req_t last_ar;

    ////////////////////////////////////////////////////////////
    // Cycle by cycle protocol watch
    ////////////////////////////////////////////////////////////

    always @(posedge aclk or negedge aresetn) begin : watch
        int inflight;
        int found;
        if (!aresetn) begin
            ar_count      <= 0;
            r_count       <= 0;
            peak_inflight <= 0;
            violations    <= 0;
            prev_wait     <= 1'b0;
            prev_ar       <= '0;
            last_ar       <= '0;
        end else begin
            inflight = ar_count - r_count;
            found    = 0;
            if (inflight > OSTD_NUM) begin
                $display("At %0t: %0d requests in flight, more than the %0d slots",
                         $time, inflight, OSTD_NUM);
                found++;
            end
            // A full slot array must keep arvalid low
            if (arvalid && inflight >= OSTD_NUM) begin
                $display("At %0t: arvalid is high while all %0d slots are busy",
                         $time, OSTD_NUM);
                found++;
            end
            if (prev_wait && (!arvalid || ar != prev_ar)) begin
                $display("At %0t: AR request changed or dropped before arready", $time);
                found++;
            end
            if (error !== (|errors)) begin
                $display("At %0t: error output does not match the OR of the error flags",
                         $time);
                found++;
            end
            if (arvalid && arready) begin
                ar_count <= ar_count + 1;
                // Same ID steps the address by one word, a new batch takes the next ID
                if (ar.addr[1:0] != 2'b00) begin
                    $display("At %0t: AR address %h is not word aligned", $time, ar.addr);
                    found++;
                end
                if (ar_count > 0 && ar.id == last_ar.id && ar.addr != last_ar.addr + 4) begin
                    $display("At %0t: AR address %h does not follow %h in its batch",
                             $time, ar.addr, last_ar.addr);
                    found++;
                end
                if (ar_count > 0 && ar.id != last_ar.id && ar.id != last_ar.id + 1'b1) begin
                    $display("At %0t: AR id %0d does not follow id %0d",
                             $time, ar.id, last_ar.id);
                    found++;
                end
                last_ar <= ar;
            end
            if (rvalid && rready) begin
                r_count <= r_count + 1;
            end
            if (inflight > peak_inflight) begin
                peak_inflight <= inflight;
            end
            violations <= violations + found;
            prev_wait  <= arvalid && !arready;
            prev_ar    <= ar;
        end
    end

    ////////////////////////////////////////////////////////////
    // Grading and summary
    ////////////////////////////////////////////////////////////

    task automatic report_problem(input string what);
        $display("At %0t: %s", $time, what);
        extra_problems++;
    endtask

    // While reset is held arvalid, rready and error are low and no flag is set
    task automatic check_reset_outputs(input string name);
        logic [6:0] actual;
        actual = {arvalid, rready, error, errors};
        if (actual !== 7'b0) begin
            $display("[FAIL] %s reset outputs expected %b actual %b", name, 7'b0, actual);
            extra_problems++;
        end
    endtask

    task automatic finish_test(input string name, input err_flags_t expected);
        int problems;
        problems = violations + extra_problems;
        extra_problems = 0;
        tests_run++;
        if (errors !== expected) begin
            $display("[FAIL] %s expected %b actual %b", name, expected, errors);
            tests_failed++;
        end else if (problems != 0) begin
            $display("Test %s failed: %0d protocol checks went wrong", name, problems);
            tests_failed++;
        end else if (!expected.ar_timeout && r_count == 0) begin
            $display("Test %s failed: no read response ever completed", name);
            tests_failed++;
        end else if (expected.slot_timeout && peak_inflight != OSTD_NUM) begin
            $display("Test %s failed: the slots never all became busy", name);
            tests_failed++;
        end else begin
            $display("[PASS] %s ar=%0d r=%0d peak=%0d flags=%b",
                     name, ar_count, r_count, peak_inflight, errors);
        end
    endtask

    task automatic print_summary();
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
    endtask

endmodule

`default_nettype wire

// File: bench/read_traffic_tb.sv
/* Runs every line of the case file against the driver with an in-order memory model
   The case file path is relative to the project root */

`timescale 1ns/1ps
`default_nettype none

module read_traffic_tb;
    import rdrv_pkg::*;

    localparam string CASE_FILE        = "bench/read_traffic_cases.txt";
    localparam int    RESET_CYCLES     = 16;
    localparam int    FIRST_AR_TIMEOUT = 200;
    localparam int    MAX_SIM_CYCLES   = 40000;
    // Response number that the fault modes act on
    localparam int    FAULT_BEAT       = 3;

    typedef enum logic [2:0] {
        MODE_CLEAN,
        MODE_FLIP_DATA,
        MODE_BAD_ID,
        MODE_DROP,
        MODE_HOLD_AR
    } resp_mode_t;

    logic       aclk;
    logic       aresetn = 1'b0;
    logic       en      = 1'b0;
    logic       arvalid;
    logic       arready = 1'b0;
    ar_req_t    ar;
    logic       rvalid  = 1'b0;
    logic       rready;
    r_beat_t    r       = '0;
    err_flags_t errors;
    logic       error;

    integer     seed = 32'hb93e;
    resp_mode_t mode = MODE_CLEAN;
    ar_req_t    resp_q [$];
    logic [1:0] resp_gap;
    int         beat_idx;
    logic       dropped;

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    read_traffic_driver i_read_traffic_driver (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (en),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r),
        .errors  (errors),
        .error   (error)
    );

    read_traffic_monitor i_read_traffic_monitor (
        .aclk    (aclk),
        .aresetn (aresetn),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .errors  (errors),
        .error   (error)
    );

    // Memory contents: word address masked by the data key
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ DATA_KEY;
    endfunction

    ////////////////////////////////////////////////////////////
    // Responder with random arready and response gaps
    ////////////////////////////////////////////////////////////

    always @(posedge aclk or negedge aresetn) begin : responder
        ar_req_t     req;
        r_beat_t     beat;
        logic [31:0] rnd;
        if (!aresetn) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            r        <= '0;
            resp_gap <= '0;
            beat_idx <= 0;
            dropped  <= 1'b0;
            resp_q.delete();
        end else begin
            rnd = $random(seed);
            arready <= (mode != MODE_HOLD_AR) && (rnd[1:0] != 2'b00);
            if (arvalid && arready) begin
                resp_q.push_back(ar);
            end
            if (!rvalid || rready) begin
                if (dropped || resp_gap != '0 || resp_q.size() == 0) begin
                    rvalid <= 1'b0;
                    if (resp_gap != '0) begin
                        resp_gap <= resp_gap - 1'b1;
                    end
                end else begin
                    req       = resp_q.pop_front();
                    beat.id   = req.id;
                    beat.data = model_word(req.addr);
                    if (beat_idx == FAULT_BEAT && mode == MODE_FLIP_DATA) begin
                        beat.data = beat.data ^ (32'h1 << rnd[8:4]);
                    end
                    if (beat_idx == FAULT_BEAT && mode == MODE_BAD_ID) begin
                        beat.id = beat.id + 1'b1;
                    end
                    // Later responses cannot overtake a lost one, so the responder goes quiet
                    if (beat_idx == FAULT_BEAT && mode == MODE_DROP) begin
                        dropped <= 1'b1;
                        rvalid  <= 1'b0;
                    end else begin
                        r      <= beat;
                        rvalid <= 1'b1;
                    end
                    beat_idx <= beat_idx + 1;
                    resp_gap <= rnd[3:2];
                end
            end
        end
    end

    initial begin : watchdog
        for (int i = 0; i < MAX_SIM_CYCLES; i++) begin
            @(posedge aclk);
        end
        $display("Simulation ran past %0d cycles without finishing", MAX_SIM_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    task automatic run_case(input string name, input int mode_val, input int budget,
                            input logic [3:0] flags);
        int waited;
        @(posedge aclk);
        aresetn <= 1'b0;
        en      <= 1'b0;
        mode    <= resp_mode_t'(mode_val[2:0]);
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge aclk);
        end
        i_read_traffic_monitor.check_reset_outputs(name);
        aresetn <= 1'b1;
        @(posedge aclk);
        en <= 1'b1;
        waited = 0;
        if (mode != MODE_HOLD_AR) begin
            while (i_read_traffic_monitor.ar_count == 0 && waited < FIRST_AR_TIMEOUT) begin
                @(posedge aclk);
                waited++;
            end
            if (i_read_traffic_monitor.ar_count == 0) begin
                i_read_traffic_monitor.report_problem("no AR handshake after enable");
            end
        end
        for (int i = waited; i < budget; i++) begin
            @(posedge aclk);
        end
        i_read_traffic_monitor.finish_test(name, err_flags_t'(flags));
    endtask

    initial begin : main
        int         fd;
        int         got;
        string      line;
        string      name;
        int         mode_val;
        int         budget;
        logic [3:0] flags;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the case file %s", CASE_FILE);
            $display("RESULT: FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                // Comment and blank lines do not yield all four fields
                if (got > 0 &&
                    $sscanf(line, "%s %d %d %b", name, mode_val, budget, flags) == 4) begin
                    run_case(name, mode_val, budget, flags);
                end
            end
            $fclose(fd);
            i_read_traffic_monitor.print_summary();
            if (i_read_traffic_monitor.tests_failed == 0 &&
                i_read_traffic_monitor.tests_run > 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: build.f
source/rdrv_pkg.sv
source/read_request_gen.sv
source/outstanding_slot.sv
source/completion_checker.sv
source/read_traffic_driver.sv
bench/read_traffic_monitor.sv
bench/read_traffic_tb.sv

// File: run.sh
#!/bin/sh
# Builds the read traffic testbench with Verilator and runs it.
# The verdict comes from the simulation log.

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module read_traffic_tb -f build.f -o read_traffic_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/read_traffic_sim > "$LOG" 2>&1
cat "$LOG"

grep -q "RESULT: FAIL" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -q "RESULT: PASS" "$LOG" || { echo "Simulation gave no verdict, see $LOG"; exit 1; }
echo "Simulation passed"
exit 0

// File: bench/read_traffic_cases.txt
# name  mode  cycles  flags (binary: id_err data_err slot_timeout ar_timeout)
# modes: 0 clean, 1 flipped rdata bit, 2 bad rid, 3 dropped response, 4 arready held low
clean_short        0   800   0000
clean_long         0   3000  0000
flipped_data       1   800   0100
wrong_id           2   800   1000
dropped_response   3   800   0010
arready_held_low   4   400   0001
clean_after_errors 0   1200  0000
